// ==== Bender.yml ====
package:
  name: platform_game

sources:
  - platform_game_pkg.sv
  - rtl/level_map.sv
  - rtl/clearance_probe.sv
  - rtl/player_physics.sv
  - rtl/pixel_render.sv
  - rtl/platform_game_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/platform_game_tb.sv

// ==== platform_game.f ====
+incdir+tb
platform_game_pkg.sv
rtl/level_map.sv
rtl/clearance_probe.sv
rtl/player_physics.sv
rtl/pixel_render.sv
rtl/platform_game_top.sv
tb/platform_game_tb.sv

// ==== platform_game_pkg.sv ====
// coordinates are 10 bits wide, so world x wraps at 1024 and only tile columns 0 to 31 are reachable
`default_nettype none

package platform_game_pkg;

	// ------------------------------------------------------------------
	// geometry
	// ------------------------------------------------------------------

	// one screen or world pixel coordinate
	typedef logic [9:0] coord_t;

	// 32 pixel tiles
	localparam int TILE_SHIFT = 5;

	// level size in tiles
	localparam int MAP_ROWS = 15;
	localparam int MAP_COLS = 80;

	// player box, position names its bottom-right pixel
	localparam int PLAYER_W = 26;
	localparam int PLAYER_H = 32;

	// spawn point
	localparam int START_X = 100;
	localparam int START_Y = 33;

	// ------------------------------------------------------------------
	// tiles
	// ------------------------------------------------------------------

	// one tile code, read raw or as solid flag plus kind
	typedef union packed {
		logic [2:0] raw;
		struct packed {
			logic       solid;
			logic [1:0] kind;
		} split;
	} tile_code_u;

	localparam logic [2:0] TILE_SKY   = 3'b000;
	localparam logic [2:0] TILE_COIN  = 3'b010;
	localparam logic [2:0] TILE_BRICK = 3'b111;

	// ------------------------------------------------------------------
	// colours and keys
	// ------------------------------------------------------------------

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	localparam rgb_t COLOR_SKY    = 24'h00007f;
	localparam rgb_t COLOR_BRICK  = 24'h833d00;
	localparam rgb_t COLOR_COIN   = 24'hffc107;
	localparam rgb_t COLOR_PLAYER = 24'hf83800;
	localparam rgb_t COLOR_BLANK  = 24'h000000;

	// keyboard usage codes, A and D
	localparam logic [31:0] KEY_LEFT  = 32'h0000_0004;
	localparam logic [31:0] KEY_RIGHT = 32'h0000_0007;

	// ------------------------------------------------------------------
	// shared state
	// ------------------------------------------------------------------

	// screen position, scroll offset and facing
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t x_shift;
		logic   face_left;
	} player_state_t;

	// allowed motion for the coming frame
	typedef struct packed {
		logic [3:0] fall;
		logic [2:0] left_step;
		logic [2:0] right_step;
	} clearance_t;

endpackage

`default_nettype wire

// ==== rtl/clearance_probe.sv ====
// purely combinational, step checks look only at the target column and not the pixels between
`default_nettype none
`timescale 1ns/1ps

module clearance_probe #(
	parameter int TERMINAL_FALL = 6,
	parameter int MAX_STEP      = 4
) (
	input  wire platform_game_pkg::player_state_t player,
	input  wire logic [3:0]                       gravity,
	output      platform_game_pkg::clearance_t    clearance
);

	// index 0 is the right edge, 1 the left edge, in world x
	platform_game_pkg::coord_t [1:0] corner_x;
	// index 0 is the bottom row, 1 the top row
	platform_game_pkg::coord_t [1:0] edge_y;

	// solid hits per probe offset and corner
	logic [TERMINAL_FALL:1][1:0] fall_hit;
	logic [MAX_STEP:1][1:0]      right_hit;
	logic [MAX_STEP:1][1:0]      left_hit;

	// fall may not outrun gravity plus one
	logic [4:0] fall_limit;

	assign corner_x[0] = player.x + player.x_shift;
	assign corner_x[1] = corner_x[0] - 10'(platform_game_pkg::PLAYER_W - 1);
	assign edge_y[0]   = player.y;
	assign edge_y[1]   = player.y - 10'(platform_game_pkg::PLAYER_H - 1);

	assign fall_limit = (({1'b0, gravity} + 5'd1) > 5'(TERMINAL_FALL)) ?
		5'(TERMINAL_FALL) : ({1'b0, gravity} + 5'd1);

	// ------------------------------------------------------------------
	// fall probes, rows y+1 .. y+TERMINAL_FALL under both bottom corners
	// ------------------------------------------------------------------
	for (genvar k = 1; k <= TERMINAL_FALL; k++) begin : g_fall
		for (genvar c = 0; c < 2; c++) begin : g_corner
			platform_game_pkg::coord_t     probe_y;
			platform_game_pkg::tile_code_u tile;

			assign probe_y = player.y + 10'(k);

			level_map u_map (
				.world_x (corner_x[c]),
				.world_y (probe_y),
				.tile    (tile)
			);

			assign fall_hit[k][c] = tile.split.solid;
		end
	end

	// ------------------------------------------------------------------
	// side probes, one column beyond each edge, on top and bottom rows
	// ------------------------------------------------------------------
	for (genvar k = 1; k <= MAX_STEP; k++) begin : g_step
		for (genvar c = 0; c < 2; c++) begin : g_corner
			platform_game_pkg::coord_t     right_x;
			platform_game_pkg::coord_t     left_x;
			platform_game_pkg::tile_code_u right_tile;
			platform_game_pkg::tile_code_u left_tile;

			assign right_x = corner_x[0] + 10'(k);
			assign left_x  = corner_x[1] - 10'(k);

			level_map u_right_map (
				.world_x (right_x),
				.world_y (edge_y[c]),
				.tile    (right_tile)
			);

			level_map u_left_map (
				.world_x (left_x),
				.world_y (edge_y[c]),
				.tile    (left_tile)
			);

			assign right_hit[k][c] = right_tile.split.solid;
			assign left_hit[k][c]  = left_tile.split.solid;
		end
	end

	// ------------------------------------------------------------------
	// largest free distances
	// ------------------------------------------------------------------
	always_comb begin
		logic run_free;

		run_free  = 1'b1;
		clearance = '0;
		// fall needs every row on the way down clear
		for (int k = 1; k <= TERMINAL_FALL; k++) begin
			run_free = run_free & ~|fall_hit[k];
			if (run_free && (k <= int'(fall_limit)))
				clearance.fall = 4'(k);
		end
		// steps only need the landing column clear
		for (int k = 1; k <= MAX_STEP; k++) begin
			if (~|right_hit[k])
				clearance.right_step = 3'(k);
			if (~|left_hit[k])
				clearance.left_step = 3'(k);
		end
	end

endmodule

`default_nettype wire

// ==== rtl/level_map.sv ====
// fixed level only, anything below row 14 or right of column 79 reads as sky
`default_nettype none
`timescale 1ns/1ps

module level_map (
	input  wire platform_game_pkg::coord_t     world_x,
	input  wire platform_game_pkg::coord_t     world_y,
	output      platform_game_pkg::tile_code_u tile
);

	platform_game_pkg::coord_t row;
	platform_game_pkg::coord_t col;
	logic                      in_grid;

	// pixel to tile index
	assign row = world_y >> platform_game_pkg::TILE_SHIFT;
	assign col = world_x >> platform_game_pkg::TILE_SHIFT;

	assign in_grid = (row < 10'(platform_game_pkg::MAP_ROWS)) &&
		(col < 10'(platform_game_pkg::MAP_COLS));

	// ------------------------------------------------------------------
	// layout table
	// ------------------------------------------------------------------
	always_comb begin
		tile.raw = platform_game_pkg::TILE_SKY;
		if (in_grid) begin
			if (row >= 10'd11) begin
				// ground, four rows deep
				tile.raw = platform_game_pkg::TILE_BRICK;
			end else begin
				case (row)
					// two platform bases
					10'd10: if ((col >= 10'd14 && col <= 10'd17) ||
						(col >= 10'd25 && col <= 10'd28))
						tile.raw = platform_game_pkg::TILE_BRICK;
					10'd9: if (col == 10'd15 || col == 10'd16 ||
						(col >= 10'd26 && col <= 10'd28))
						tile.raw = platform_game_pkg::TILE_BRICK;
					// floating pair and the stair
					10'd8: if (col == 10'd19 || col == 10'd20 ||
						col == 10'd27 || col == 10'd28)
						tile.raw = platform_game_pkg::TILE_BRICK;
					10'd7: begin
						if (col == 10'd28)
							tile.raw = platform_game_pkg::TILE_BRICK;
						else if (col == 10'd20)
							tile.raw = platform_game_pkg::TILE_COIN;
					end
					// lone coin up high
					10'd5: if (col == 10'd10)
						tile.raw = platform_game_pkg::TILE_COIN;
					default: tile.raw = platform_game_pkg::TILE_SKY;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/pixel_render.sv ====
// one cycle of latency from draw position to rgb, each object drawn in one flat colour
`default_nettype none
`timescale 1ns/1ps

module pixel_render (
	input  wire                                   Clk,
	input  wire                                   Reset,
	input  wire platform_game_pkg::coord_t        draw_x,
	input  wire platform_game_pkg::coord_t        draw_y,
	input  wire                                   blank,
	input  wire platform_game_pkg::player_state_t player,
	output      platform_game_pkg::rgb_t          rgb
);

	platform_game_pkg::coord_t                world_x;
	platform_game_pkg::coord_t                dx;
	platform_game_pkg::coord_t                dy;
	logic                                     in_player;
	logic                                     coin_margin;
	logic [platform_game_pkg::TILE_SHIFT-1:0] tile_px;
	platform_game_pkg::tile_code_u            tile;
	platform_game_pkg::rgb_t                  color_next;

	// ------------------------------------------------------------------
	// player box, screen space
	// ------------------------------------------------------------------
	// distance back from the bottom-right corner
	assign dx = player.x - draw_x;
	assign dy = player.y - draw_y;

	assign in_player = (draw_x <= player.x) && (dx < 10'(platform_game_pkg::PLAYER_W)) &&
		(draw_y <= player.y) && (dy < 10'(platform_game_pkg::PLAYER_H));

	// ------------------------------------------------------------------
	// background tile, world space
	// ------------------------------------------------------------------
	assign world_x = draw_x + player.x_shift;

	level_map u_map (
		.world_x (world_x),
		.world_y (draw_y),
		.tile    (tile)
	);

	// coin art leaves two sky columns on each side
	assign tile_px     = world_x[platform_game_pkg::TILE_SHIFT-1:0];
	assign coin_margin = (tile_px <= 5'd1) || (tile_px >= 5'd30);

	// ------------------------------------------------------------------
	// priority select
	// ------------------------------------------------------------------
	always_comb begin
		if (!blank)
			color_next = platform_game_pkg::COLOR_BLANK;
		else if (in_player)
			color_next = platform_game_pkg::COLOR_PLAYER;
		else if (tile.raw == platform_game_pkg::TILE_BRICK)
			color_next = platform_game_pkg::COLOR_BRICK;
		else if (tile.raw == platform_game_pkg::TILE_COIN && !coin_margin)
			color_next = platform_game_pkg::COLOR_COIN;
		else
			color_next = platform_game_pkg::COLOR_SKY;
	end

	// output register
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset)
			rgb <= platform_game_pkg::COLOR_BLANK;
		else
			rgb <= color_next;
	end

endmodule

`default_nettype wire

// ==== rtl/platform_game_top.sv ====
// single clock design, frame_tick must be a one-cycle strobe and inputs are taken every cycle
`default_nettype none
`timescale 1ns/1ps

module platform_game_top #(
	parameter int MAX_SCREEN_X  = 384,
	parameter int TERMINAL_FALL = 6,
	parameter int MAX_STEP      = 4
) (
	input  wire                                   Clk,
	input  wire                                   Reset,
	input  wire                                   frame_tick,
	input  wire logic [31:0]                      keycode,
	input  wire platform_game_pkg::coord_t        draw_x,
	input  wire platform_game_pkg::coord_t        draw_y,
	input  wire                                   blank,
	output      platform_game_pkg::player_state_t player,
	output      platform_game_pkg::rgb_t          rgb
);

	// physics to probe and back
	platform_game_pkg::clearance_t clearance;
	logic [3:0]                    gravity;

	// ------------------------------------------------------------------
	// motion
	// ------------------------------------------------------------------
	player_physics #(
		.MAX_SCREEN_X  (MAX_SCREEN_X),
		.TERMINAL_FALL (TERMINAL_FALL)
	) u_physics (
		.Clk        (Clk),
		.Reset      (Reset),
		.frame_tick (frame_tick),
		.keycode    (keycode),
		.clearance  (clearance),
		.gravity    (gravity),
		.player     (player)
	);

	clearance_probe #(
		.TERMINAL_FALL (TERMINAL_FALL),
		.MAX_STEP      (MAX_STEP)
	) u_probe (
		.player    (player),
		.gravity   (gravity),
		.clearance (clearance)
	);

	// ------------------------------------------------------------------
	// drawing
	// ------------------------------------------------------------------
	pixel_render u_render (
		.Clk    (Clk),
		.Reset  (Reset),
		.draw_x (draw_x),
		.draw_y (draw_y),
		.blank  (blank),
		.player (player),
		.rgb    (rgb)
	);

endmodule

`default_nettype wire

// ==== rtl/player_physics.sv ====
// state moves only on frame_tick, no scroll back to the left and no guard against x wrapping below 0
`default_nettype none
`timescale 1ns/1ps

module player_physics #(
	parameter int MAX_SCREEN_X  = 384,
	parameter int TERMINAL_FALL = 6
) (
	input  wire                                   Clk,
	input  wire                                   Reset,
	input  wire                                   frame_tick,
	input  wire logic [31:0]                      keycode,
	input  wire platform_game_pkg::clearance_t    clearance,
	output      logic [3:0]                       gravity,
	output      platform_game_pkg::player_state_t player
);

	logic signed [10:0]               step;
	logic signed [10:0]               x_sum;
	logic signed [10:0]               scroll;
	logic                             face_left_next;
	logic [3:0]                       gravity_next;
	platform_game_pkg::player_state_t player_next;

	// ------------------------------------------------------------------
	// key decode
	// ------------------------------------------------------------------
	always_comb begin
		step           = '0;
		face_left_next = player.face_left;
		if (keycode == platform_game_pkg::KEY_RIGHT) begin
			step           = $signed({8'd0, clearance.right_step});
			face_left_next = 1'b0;
		end else if (keycode == platform_game_pkg::KEY_LEFT) begin
			step           = -$signed({8'd0, clearance.left_step});
			face_left_next = 1'b1;
		end
	end

	// gravity saturates at terminal speed
	assign gravity_next = (clearance.fall > 4'(TERMINAL_FALL)) ?
		4'(TERMINAL_FALL) : clearance.fall;

	// ------------------------------------------------------------------
	// next position
	// ------------------------------------------------------------------
	assign x_sum = $signed({1'b0, player.x}) + step;

	always_comb begin
		player_next           = player;
		player_next.face_left = face_left_next;
		player_next.y         = player.y + {6'd0, clearance.fall};
		scroll                = '0;
		if (x_sum > $signed(11'(MAX_SCREEN_X))) begin
			// past the screen limit, the overshoot becomes scroll
			player_next.x = 10'(MAX_SCREEN_X);
			scroll        = x_sum - $signed(11'(MAX_SCREEN_X));
		end else begin
			player_next.x = x_sum[9:0];
		end
		player_next.x_shift = player.x_shift + scroll[9:0];
	end

	// ------------------------------------------------------------------
	// state registers, update once per frame
	// ------------------------------------------------------------------
	always_ff @(posedge Clk or posedge Reset) begin
		if (Reset) begin
			player.x         <= 10'(platform_game_pkg::START_X);
			player.y         <= 10'(platform_game_pkg::START_Y);
			player.x_shift   <= '0;
			player.face_left <= 1'b0;
			gravity          <= '0;
		end else if (frame_tick) begin
			player  <= player_next;
			gravity <= gravity_next;
		end
	end

endmodule

`default_nettype wire

// ==== tb/platform_game_checks.svh ====
// included inside platform_game_tb only, relies on its phase, check_rgb and expected_rgb signals
`ifndef PLATFORM_GAME_CHECKS_SVH
`define PLATFORM_GAME_CHECKS_SVH

// ----------------------------------------------------------------------
// reference level, tile code of one world pixel
// ----------------------------------------------------------------------
task automatic reference_tile(input int wx, input int wy, output logic [2:0] code);
	int row;
	int col;

	row  = wy / 32;
	col  = wx / 32;
	code = 3'b000;
	// outside the grid stays sky
	if (row >= 15 || col >= 80)
		code = 3'b000;
	else if (row >= 11)
		code = 3'b111;
	else if (row == 10 && ((col >= 14 && col <= 17) || (col >= 25 && col <= 28)))
		code = 3'b111;
	else if (row == 9 && (col == 15 || col == 16 || (col >= 26 && col <= 28)))
		code = 3'b111;
	else if (row == 8 && (col == 19 || col == 20 || col == 27 || col == 28))
		code = 3'b111;
	else if (row == 7 && col == 28)
		code = 3'b111;
	else if ((row == 7 && col == 20) || (row == 5 && col == 10))
		code = 3'b010;
endtask

// ----------------------------------------------------------------------
// motion and render checks
// ----------------------------------------------------------------------
// spawn state held through reset and its release
a_reset: assert property (@(posedge Clk) (Reset || $fell(Reset)) |-> (player.x == 10'd100 &&
	player.y == 10'd33 && player.x_shift == '0 && !player.face_left && rgb == '0))
	else flag_error("player or rgb not in the reset state");
a_fall_rate: assert property (@(posedge Clk) disable iff (Reset) frame_tick |=>
	(player.y >= $past(player.y) && player.y <= $past(player.y) + TERMINAL_FALL))
	else flag_error("y fell back or faster than terminal speed");
a_landed: assert property (@(posedge Clk) disable iff (Reset) (int'(player.y) == LAND_Y) |=>
	(int'(player.y) == LAND_Y)) else flag_error("player left the ground row");
// no key, no sideways motion and no turn
a_idle: assert property (@(posedge Clk) disable iff (Reset) (frame_tick &&
	keycode != platform_game_pkg::KEY_LEFT && keycode != platform_game_pkg::KEY_RIGHT) |=>
	($stable(player.x) && $stable(player.x_shift) && $stable(player.face_left)))
	else flag_error("x, x_shift or facing moved with no key");
a_right: assert property (@(posedge Clk) disable iff (Reset) (phase == PH_RIGHT && frame_tick)
	|=> (player.x_shift >= $past(player.x_shift) && !player.face_left &&
	player.x_shift <= $past(player.x_shift) + MAX_STEP))
	else flag_error("bad scroll step or facing while walking right");
a_bounds: assert property (@(posedge Clk) disable iff (Reset) (player.x <= MAX_SCREEN_X &&
	int'(player.x) + int'(player.x_shift) < BLOCK_X))
	else flag_error("player past the screen limit or into the platform");
a_left: assert property (@(posedge Clk) disable iff (Reset) (phase == PH_LEFT && frame_tick)
	|=> (player.face_left && player.x_shift <= $past(player.x_shift) &&
	player.x_shift + MAX_STEP >= $past(player.x_shift)))
	else flag_error("bad scroll step or facing while walking left");
a_release: assert property (@(posedge Clk) disable iff (Reset) (phase == PH_RELEASE) |->
	player.face_left) else flag_error("facing lost after the left key was released");
a_render: assert property (@(posedge Clk) disable iff (Reset) check_rgb |=>
	(rgb == $past(expected_rgb))) else flag_error("rgb differs from the expected colour");

`endif

// ==== tb/platform_game_tb.sv ====
// one clock, frame_tick every 8 cycles, inputs change 2 ns after each rising edge of Clk
`default_nettype none
`timescale 1ns/1ps

module platform_game_tb;

	localparam int MAX_SCREEN_X  = 384;
	localparam int TERMINAL_FALL = 6;
	localparam int MAX_STEP      = 4;
	// last free row above the ground bricks
	localparam int LAND_Y        = 11 * 32 - 1;
	// left side of the column 14 platform
	localparam int BLOCK_X       = 14 * 32;

	// stimulus phases
	localparam int PH_RESET   = 0;
	localparam int PH_FALL    = 1;
	localparam int PH_RIGHT   = 2;
	localparam int PH_LEFT    = 3;
	localparam int PH_RELEASE = 4;
	localparam int PH_RENDER  = 5;

	logic                             Clk;
	logic                             Reset;
	logic                             frame_tick;
	logic [31:0]                      keycode;
	platform_game_pkg::coord_t        draw_x;
	platform_game_pkg::coord_t        draw_y;
	logic                             blank;
	platform_game_pkg::player_state_t player;
	platform_game_pkg::rgb_t          rgb;

	int                               phase;
	int                               tick_div;
	int                               tick_count;
	int                               error_count;
	int                               pixel_count;
	int                               seed;
	logic                             check_rgb;
	platform_game_pkg::rgb_t          expected_rgb;

	platform_game_top #(
		.MAX_SCREEN_X  (MAX_SCREEN_X),
		.TERMINAL_FALL (TERMINAL_FALL),
		.MAX_STEP      (MAX_STEP)
	) dut (
		.Clk        (Clk),
		.Reset      (Reset),
		.frame_tick (frame_tick),
		.keycode    (keycode),
		.draw_x     (draw_x),
		.draw_y     (draw_y),
		.blank      (blank),
		.player     (player),
		.rgb        (rgb)
	);

	`include "platform_game_checks.svh"

	// 20 ns period
	always #10 Clk = ~Clk;

	// one-cycle frame strobe, counted only when reset is low at the edge
	always @(posedge Clk) begin : frame_gen
		logic counting;

		counting = !Reset;
		#2;
		frame_tick = 1'b0;
		if (counting) begin
			tick_div = (tick_div + 1) % 8;
			if (tick_div == 0) begin
				frame_tick = 1'b1;
				tick_count++;
			end
		end
	end

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge Clk);
		#2;
	endtask

	task automatic flag_error(input string msg);
		error_count++;
		$display("[ERROR] %0t ns: %s", $time, msg);
	endtask

	// colour rules from the player box and the reference level
	task automatic expected_color(input int px, input int py, input logic b,
		output platform_game_pkg::rgb_t c);
		logic [2:0] code;
		int         wx;

		wx = (px + int'(player.x_shift)) % 1024;
		reference_tile(wx, py, code);
		if (!b)
			c = platform_game_pkg::COLOR_BLANK;
		else if (px <= int'(player.x) && px >= int'(player.x) - 25 &&
			py <= int'(player.y) && py >= int'(player.y) - 31)
			c = platform_game_pkg::COLOR_PLAYER;
		else if (code == 3'b111)
			c = platform_game_pkg::COLOR_BRICK;
		else if (code == 3'b010 && (wx % 32) >= 2 && (wx % 32) <= 29)
			c = platform_game_pkg::COLOR_COIN;
		else
			c = platform_game_pkg::COLOR_SKY;
	endtask

	// drive one draw point and compare it one cycle later
	task automatic check_pixel(input platform_game_pkg::coord_t x,
		input platform_game_pkg::coord_t y, input logic b,
		input platform_game_pkg::rgb_t want);
		draw_x       = x;
		draw_y       = y;
		blank        = b;
		expected_rgb = want;
		check_rgb    = 1'b1;
		pixel_count++;
		next_cycle();
	endtask

	task automatic finish_run(input bit stalled);
		$display("summary: %0d errors, %0d pixel checks, %0d frame ticks",
			error_count, pixel_count, tick_count);
		if (error_count == 0 && !stalled)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	endtask

	// ------------------------------------------------------------------
	// stimulus phases
	// ------------------------------------------------------------------
	task automatic run_phases(output string stalled);
		int                      n;
		int                      px;
		int                      py;
		logic                    b;
		platform_game_pkg::rgb_t want;

		stalled = "";
		// reset held over 16 rising edges
		#1;
		Reset = 1'b1;
		repeat (16) next_cycle();
		Reset = 1'b0;
		blank = 1'b1;
		// drop to the ground with no key held
		phase = PH_FALL;
		for (n = 0; n < 2000 && int'(player.y) != LAND_Y; n++)
			next_cycle();
		if (int'(player.y) != LAND_Y) begin
			stalled = "fall";
			return;
		end
		repeat (40) next_cycle();
		// walk until the platform stops the right edge
		phase   = PH_RIGHT;
		keycode = platform_game_pkg::KEY_RIGHT;
		for (n = 0; n < 2000 && int'(player.x) + int'(player.x_shift) != BLOCK_X - 1; n++)
			next_cycle();
		if (int'(player.x) + int'(player.x_shift) != BLOCK_X - 1) begin
			stalled = "walk right";
			return;
		end
		repeat (40) next_cycle();
		phase   = PH_LEFT;
		keycode = platform_game_pkg::KEY_LEFT;
		for (n = 0; n < 1000 && player.x > 10'd320; n++)
			next_cycle();
		if (player.x > 10'd320) begin
			stalled = "walk left";
			return;
		end
		phase   = PH_RELEASE;
		keycode = '0;
		repeat (40) next_cycle();
		// player now at rest so directed points go first
		phase = PH_RENDER;
		check_pixel(10'd5, 10'd5, 1'b0, platform_game_pkg::COLOR_BLANK);
		check_pixel(player.x - 10'd10, player.y - 10'd10, 1'b1,
			platform_game_pkg::COLOR_PLAYER);
		check_pixel(10'd10, 10'd400, 1'b1, platform_game_pkg::COLOR_BRICK);
		check_pixel(10'd336 - player.x_shift, 10'd176, 1'b1, platform_game_pkg::COLOR_COIN);
		check_pixel(10'd320 - player.x_shift, 10'd176, 1'b1, platform_game_pkg::COLOR_SKY);
		check_pixel(10'd10, 10'd10, 1'b1, platform_game_pkg::COLOR_SKY);
		for (n = 0; n < 400; n++) begin
			px = {$random(seed)} % 640;
			py = {$random(seed)} % 480;
			// mostly visible points
			b  = ({$random(seed)} % 8) != 0;
			expected_color(px, py, b, want);
			check_pixel(10'(px), 10'(py), b, want);
		end
		check_rgb = 1'b0;
		repeat (2) next_cycle();
	endtask

	initial begin
		string stalled;

		seed         = 93738;
		Clk          = 1'b0;
		Reset        = 1'b0;
		frame_tick   = 1'b0;
		keycode      = '0;
		draw_x       = '0;
		draw_y       = '0;
		blank        = 1'b0;
		phase        = PH_RESET;
		tick_div     = 0;
		tick_count   = 0;
		error_count  = 0;
		pixel_count  = 0;
		check_rgb    = 1'b0;
		expected_rgb = '0;
		run_phases(stalled);
		if (stalled != "")
			$display("timeout: the %s phase stalled before its goal was reached", stalled);
		finish_run(stalled != "");
	end

endmodule

`default_nettype wire
